/* build.f */
rtl/switch_pkg.sv
rtl/ingress_arbiter.sv
rtl/cell_buffer.sv
rtl/egress_queues.sv
rtl/egress_reader.sv
rtl/switch_top.sv
testbench/tb_switch.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_switch
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_switch.sv */
module tb_switch;
    import switch_pkg::*;

    typedef struct packed {
        port_idx_t   src;
        port_idx_t   dst;
        prio_t       prio;
        logic [4:0]  len;     // Words, header included
        logic [15:0] start;   // Earliest cycle for the sop
    } pkt_entry_t;

    localparam int PAT_LEN   = 8192;
    localparam int HIGH_LAST = 6;              // Port 2 stays blocked until this entry is in
    localparam int NEVER     = 32'h7fff_ffff;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [NUM_PORTS-1:0]  wr_sop, wr_eop, wr_vld, ready;
    word_t [NUM_PORTS-1:0] wr_data;
    logic [NUM_PORTS-1:0]  pause, rd_sop, rd_eop, rd_vld;
    word_t [NUM_PORTS-1:0] rd_data;
    logic                  full, almost_full;

    pkt_entry_t           stim [$];
    logic [17:0]          exp_q [NUM_PORTS*NUM_PRIOS][$];   // {sop, eop, data}
    logic [NUM_PORTS-1:0] ready_pat [PAT_LEN];
    int                   cycle       = 0;
    int                   limit       = NEVER;
    int                   total_words = 0;
    int                   words_out   = 0;
    int                   free_model  = NUM_CELLS;
    int                   rel2        = NEVER;
    int                   rel3        = NEVER;
    int                   cur_q [NUM_PORTS];
    int                   pkts_out [NUM_PORTS];
    logic                 locked_m    = 1'b0;
    port_idx_t            owner_m;
    logic                 saw_af      = 1'b0;
    logic                 saw_full    = 1'b0;

    switch_top dut0 (.*);

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic add_packet(input int src, input int dst, input int prio,
                              input int len, input int start);
        pkt_entry_t e;
        e.src   = port_idx_t'(src);
        e.dst   = port_idx_t'(dst);
        e.prio  = prio_t'(prio);
        e.len   = 5'(len);
        e.start = 16'(start);
        stim.push_back(e);
        total_words += len;
    endtask

    task automatic idle_inputs();
        wr_vld  = '0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_data = '0;
    endtask

    // ==============================
    // Cycle count and timeout
    // ==============================
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > limit) begin
            $display("Timeout after %0d cycles, traffic did not drain", cycle);
            $display("sim failed");
            $fatal(1);
        end
    end

    // Random ready with the hold windows for ports 2 and 3
    initial begin
        logic [NUM_PORTS-1:0] mask;
        ready = '0;
        forever begin
            @(posedge clk);
            #10;
            mask = ready_pat[cycle % PAT_LEN];
            if (cycle < rel2) mask[2] = 1'b0;
            if (cycle < rel3) mask[3] = 1'b0;
            ready = mask;
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        pkt_entry_t e;
        word_t      w;
        void'($urandom(7));
        rst_n = 1'b0;
        idle_inputs();
        for (int i = 0; i < PAT_LEN; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                ready_pat[i][p] = ($urandom() % 4) != 0;   // Ready about 3 cycles in 4
            end
        end
        // src, dst, prio, len, start
        add_packet(0, 1, 0, 4, 0);
        add_packet(2, 1, 0, 1, 0);
        add_packet(3, 1, 0, 7, 0);
        add_packet(1, 0, 1, 16, 0);
        add_packet(1, 0, 0, 5, 0);
        // Both priorities wait behind a blocked port 2
        add_packet(1, 2, 0, 3, 120);
        add_packet(3, 2, 1, 6, 120);
        add_packet(0, 2, 0, 2, 120);
        // Fill the buffer behind port 3, then resume
        add_packet(0, 3, 0, 16, 250);
        add_packet(1, 3, 1, 16, 250);
        add_packet(2, 3, 0, 16, 250);
        add_packet(3, 3, 1, 16, 250);
        add_packet(2, 3, 0, 8, 250);
        add_packet(0, 1, 1, 3, 250);
        limit = 40 * total_words;

        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;

        foreach (stim[i]) begin
            e = stim[i];
            do begin
                @(posedge clk);
                #10;
                idle_inputs();
            end while (cycle < int'(e.start) || pause[e.src]);
            for (int k = 0; k < int'(e.len); k++) begin
                if (k > 0) begin
                    @(posedge clk);
                    #10;
                end
                w = word_t'($urandom());
                if (k == 0) begin
                    w[1:0] = e.dst;     // Header destination
                    w[2]   = e.prio;
                end
                exp_q[int'(e.dst) * NUM_PRIOS + int'(e.prio)].push_back(
                    {k == 0, k == int'(e.len) - 1, w});
                wr_vld[e.src]  = 1'b1;
                wr_sop[e.src]  = (k == 0);
                wr_eop[e.src]  = (k == int'(e.len) - 1);
                wr_data[e.src] = w;
            end
            if (i == HIGH_LAST) rel2 = cycle + 6;   // Both port 2 priorities queued by then
        end
        @(posedge clk);
        #10;
        idle_inputs();

        while (words_out != total_words) begin
            @(posedge clk);
        end
        #10;
        check("almost_full after drain", 0, 32'(almost_full));
        check("full after drain", 0, 32'(full));
        check("almost_full seen", 1, 32'(saw_af));
        check("full seen", 1, 32'(saw_full));
        $display("sim passed");
        $finish;
    end

    // ==============================
    // Output and flag monitor
    // ==============================
    always @(negedge clk) begin
        logic [NUM_PORTS-1:0] acc;
        logic [NUM_PORTS-1:0] exp_pause;
        logic [17:0]          exp_word;
        if (rst_n) begin
            check("almost_full", 32'(free_model < NUM_CELLS / 2), 32'(almost_full));
            check("full", 32'(free_model == 0), 32'(full));
            check("rd_vld while ready low", 0, 32'(rd_vld & ~ready));
            exp_pause = '1;
            if (locked_m) begin
                exp_pause[owner_m] = 1'b0;          // Only the owner may continue
                check("pause during packet", 32'(exp_pause), 32'(pause));
            end else if (free_model < MAX_PKT_WORDS) begin
                check("pause without room", 32'(exp_pause), 32'(pause));
            end
            saw_af = saw_af | almost_full;
            if (full && !saw_full) begin
                saw_full = 1'b1;
                rel3     = cycle + 20;              // Keep port 3 blocked a while when full
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rd_vld[p]) begin
                    if (rd_sop[p]) begin
                        cur_q[p] = p * NUM_PRIOS + int'(rd_data[p][2]);
                        if (p == 2 && pkts_out[p] == 0) begin
                            check("high priority first on port 2", 1, 32'(rd_data[p][2]));
                        end
                    end
                    if (exp_q[cur_q[p]].size() == 0) begin
                        $display("Output port %0d sent a word that no packet expects", p);
                        $display("sim failed");
                        $fatal(1);
                    end else begin
                        exp_word = exp_q[cur_q[p]].pop_front();
                        check($sformatf("word on port %0d", p), 32'(exp_word),
                              32'({rd_sop[p], rd_eop[p], rd_data[p]}));
                        if (rd_eop[p]) pkts_out[p]++;
                        words_out++;
                        free_model++;
                    end
                end
            end
            acc = wr_vld & ~pause;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (acc[p]) begin
                    free_model--;
                    if (wr_sop[p] && !wr_eop[p]) begin
                        locked_m = 1'b1;
                        owner_m  = port_idx_t'(p);
                    end else if (wr_eop[p]) begin
                        locked_m = 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* rtl/switch_top.sv */
module switch_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]       wr_sop,
    input  logic [switch_pkg::NUM_PORTS-1:0]       wr_eop,
    input  logic [switch_pkg::NUM_PORTS-1:0]       wr_vld,
    input  switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] wr_data,
    input  logic [switch_pkg::NUM_PORTS-1:0]       ready,
    output logic [switch_pkg::NUM_PORTS-1:0]       pause,
    output logic [switch_pkg::NUM_PORTS-1:0]       rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]       rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]       rd_vld,
    output switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data,
    output logic                                   full,
    output logic                                   almost_full
);
    import switch_pkg::*;

    // Ingress to buffer
    logic       acc_vld, acc_sop, acc_eop, room;
    word_t      acc_word;
    // Buffer and queues
    enq_req_t   enq;
    logic       link_req;
    cell_addr_t link_from, link_to;
    // Queues and reader
    logic       grant_vld, reader_idle, pkt_done;
    port_idx_t  grant_port;
    cell_addr_t grant_head, pkt_next;
    // Reader and buffer
    cell_addr_t rd_addr, rd_next, free_addr;
    cell_t      rd_cell;
    logic       free_vld;

    ingress_arbiter u_ingress (
        .clk, .rst_n, .wr_sop, .wr_eop, .wr_vld, .wr_data, .room,
        .pause, .acc_vld, .acc_sop, .acc_eop, .acc_word
    );

    cell_buffer u_buffer (
        .clk, .rst_n, .acc_vld, .acc_sop, .acc_eop, .acc_word,
        .link_req, .link_from, .link_to, .rd_addr, .free_vld, .free_addr,
        .enq, .rd_cell, .rd_next, .room, .full, .almost_full
    );

    egress_queues u_queues (
        .clk, .rst_n, .enq, .ready, .reader_idle, .pkt_done, .pkt_next,
        .link_req, .link_from, .link_to, .grant_vld, .grant_port, .grant_head
    );

    egress_reader u_reader (
        .clk, .rst_n, .grant_vld, .grant_port, .grant_head, .ready,
        .rd_cell, .rd_next, .rd_addr, .free_vld, .free_addr,
        .reader_idle, .pkt_done, .pkt_next,
        .rd_sop, .rd_eop, .rd_vld, .rd_data
    );

endmodule

/* rtl/egress_reader.sv */
module egress_reader (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   grant_vld,
    input  switch_pkg::port_idx_t                  grant_port,
    input  switch_pkg::cell_addr_t                 grant_head,
    input  logic [switch_pkg::NUM_PORTS-1:0]       ready,
    input  switch_pkg::cell_t                      rd_cell,
    input  switch_pkg::cell_addr_t                 rd_next,
    output switch_pkg::cell_addr_t                 rd_addr,
    output logic                                   free_vld,
    output switch_pkg::cell_addr_t                 free_addr,
    output logic                                   reader_idle,
    output logic                                   pkt_done,
    output switch_pkg::cell_addr_t                 pkt_next,
    output logic [switch_pkg::NUM_PORTS-1:0]       rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]       rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]       rd_vld,
    output switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data
);
    import switch_pkg::*;

    rd_state_t  state;
    port_idx_t  port_q;   // Output port being served
    cell_addr_t cur;      // Cell on rd_cell while streaming
    logic       first;    // Next word sent is the header
    logic       send;

    assign send = (state == STREAM) && ready[port_q];

    // Read ahead so a word leaves every cycle while ready stays high
    assign rd_addr     = (send && !rd_cell.eop) ? rd_next : cur;
    assign reader_idle = (state == IDLE);
    assign free_vld    = send;
    assign free_addr   = cur;
    assign pkt_done    = send && rd_cell.eop;
    assign pkt_next    = rd_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            first <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (grant_vld) begin
                        state <= FETCH;
                        first <= 1'b1;
                    end
                end
                FETCH: state <= STREAM;   // Read latency of the buffer
                STREAM: begin
                    if (send) first <= 1'b0;
                    if (pkt_done) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && grant_vld) begin
            cur    <= grant_head;
            port_q <= grant_port;
        end else if (send) begin
            cur <= rd_next;
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rd_vld[p]  = send && port_q == port_idx_t'(p);
            rd_sop[p]  = rd_vld[p] && first;
            rd_eop[p]  = rd_vld[p] && rd_cell.eop;
            rd_data[p] = rd_cell.data;
        end
    end

endmodule

/* rtl/egress_queues.sv */
module egress_queues (
    input  logic                               clk,
    input  logic                               rst_n,
    input  switch_pkg::enq_req_t               enq,
    input  logic [switch_pkg::NUM_PORTS-1:0]   ready,
    input  logic                               reader_idle,
    input  logic                               pkt_done,
    input  switch_pkg::cell_addr_t             pkt_next,
    output logic                               link_req,
    output switch_pkg::cell_addr_t             link_from,
    output switch_pkg::cell_addr_t             link_to,
    output logic                               grant_vld,
    output switch_pkg::port_idx_t              grant_port,
    output switch_pkg::cell_addr_t             grant_head
);
    import switch_pkg::*;

    cell_addr_t head      [NUM_PORTS][NUM_PRIOS];
    cell_addr_t tail      [NUM_PORTS][NUM_PRIOS];
    cell_addr_t last_head [NUM_PORTS][NUM_PRIOS];   // Head cell of the newest packet
    logic [NUM_PRIOS-1:0] q_empty [NUM_PORTS];

    logic [NUM_PRIOS-1:0] enq_hit  [NUM_PORTS];
    logic [NUM_PRIOS-1:0] done_hit [NUM_PORTS];
    logic [NUM_PRIOS-1:0] drained  [NUM_PORTS];    // Last packet of the queue has left

    port_idx_t rr_ptr;
    port_idx_t cand;
    port_idx_t sel_port;
    prio_t     sel_prio;
    logic      sel_found;
    port_idx_t gnt_port;
    prio_t     gnt_prio;

    // Append to a non-empty queue by chaining old tail to new head
    assign link_req  = enq.valid && !q_empty[enq.dest][enq.prio];
    assign link_from = tail[enq.dest][enq.prio];
    assign link_to   = enq.head;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int r = 0; r < NUM_PRIOS; r++) begin
                enq_hit[p][r]  = enq.valid && enq.dest == port_idx_t'(p)
                                 && enq.prio == prio_t'(r);
                done_hit[p][r] = pkt_done && gnt_port == port_idx_t'(p)
                                 && gnt_prio == prio_t'(r);
                drained[p][r]  = done_hit[p][r] && head[p][r] == last_head[p][r];
            end
        end
    end

    // ==============================
    // Round-robin port selection
    // ==============================
    always_comb begin
        sel_found = 1'b0;
        sel_port  = rr_ptr;
        cand      = rr_ptr;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand = rr_ptr + port_idx_t'(i);
            if (!sel_found && ready[cand] && !(&q_empty[cand])) begin
                sel_found = 1'b1;
                sel_port  = cand;
            end
        end
        sel_prio = prio_t'(!q_empty[sel_port][1]);   // High queue first
    end

    assign grant_vld  = reader_idle && sel_found;
    assign grant_port = sel_port;
    assign grant_head = head[sel_port][sel_prio];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (grant_vld) begin
            rr_ptr <= sel_port + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_vld) begin
            gnt_port <= sel_port;
            gnt_prio <= sel_prio;
        end
    end

    // ==============================
    // Queue pointers
    // ==============================
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int r = 0; r < NUM_PRIOS; r++) begin
                if (enq_hit[p][r]) begin
                    tail[p][r]      <= enq.tail;
                    last_head[p][r] <= enq.head;
                end
                if (enq_hit[p][r] && (q_empty[p][r] || drained[p][r])) begin
                    head[p][r] <= enq.head;
                end else if (done_hit[p][r] && !drained[p][r]) begin
                    head[p][r] <= pkt_next;   // Step to the next packet
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int r = 0; r < NUM_PRIOS; r++) begin
                if (!rst_n)              q_empty[p][r] <= 1'b1;
                else if (enq_hit[p][r])  q_empty[p][r] <= 1'b0;
                else if (drained[p][r])  q_empty[p][r] <= 1'b1;
            end
        end
    end

endmodule

/* rtl/cell_buffer.sv */
module cell_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    acc_vld,
    input  logic                    acc_sop,
    input  logic                    acc_eop,
    input  switch_pkg::word_t       acc_word,
    input  logic                    link_req,
    input  switch_pkg::cell_addr_t  link_from,
    input  switch_pkg::cell_addr_t  link_to,
    input  switch_pkg::cell_addr_t  rd_addr,
    input  logic                    free_vld,
    input  switch_pkg::cell_addr_t  free_addr,
    output switch_pkg::enq_req_t    enq,
    output switch_pkg::cell_t       rd_cell,
    output switch_pkg::cell_addr_t  rd_next,
    output logic                    room,
    output logic                    full,
    output logic                    almost_full
);
    import switch_pkg::*;

    cell_t       cell_mem [NUM_CELLS];
    cell_addr_t  link_mem [NUM_CELLS];   // Next cell of each cell
    cell_addr_t  fl_mem   [NUM_CELLS];   // Free list FIFO

    cell_addr_t  fl_rd;
    cell_addr_t  fl_wr;
    cell_count_t init_ptr;               // Cells never handed out since reset
    cell_count_t free_cnt;
    cell_addr_t  alloc_addr;

    cell_addr_t  pkt_head;               // First cell of the open packet
    cell_addr_t  last_cell;              // Most recent cell of the open packet
    port_idx_t   hdr_dest;
    prio_t       hdr_prio;

    logic        lnk_we;
    cell_addr_t  lnk_addr;
    cell_addr_t  lnk_data;

    // ==============================
    // Free list
    // ==============================
    assign alloc_addr = (init_ptr < NUM_CELLS) ? cell_addr_t'(init_ptr) : fl_mem[fl_rd];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fl_rd    <= '0;
            fl_wr    <= '0;
            init_ptr <= '0;
            free_cnt <= cell_count_t'(NUM_CELLS);
        end else begin
            if (acc_vld) begin
                if (init_ptr < NUM_CELLS) init_ptr <= init_ptr + 1'b1;
                else                      fl_rd    <= fl_rd + 1'b1;
            end
            if (free_vld) fl_wr <= fl_wr + 1'b1;
            free_cnt <= free_cnt + cell_count_t'(free_vld) - cell_count_t'(acc_vld);
        end
    end

    always_ff @(posedge clk) begin
        if (free_vld) fl_mem[fl_wr] <= free_addr;
    end

    assign full        = (free_cnt == '0);
    assign almost_full = (free_cnt < NUM_CELLS / 2);
    assign room        = (free_cnt >= MAX_PKT_WORDS);

    // ==============================
    // Packet write and enqueue
    // ==============================
    always_ff @(posedge clk) begin
        if (acc_vld) begin
            cell_mem[alloc_addr] <= '{data: acc_word, eop: acc_eop};
            last_cell            <= alloc_addr;
            if (acc_sop) begin
                pkt_head <= alloc_addr;
                hdr_dest <= port_idx_t'(acc_word[1:0]);   // Header bits 1:0
                hdr_prio <= prio_t'(acc_word[2]);         // Header bit 2
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enq.valid <= 1'b0;
        end else begin
            enq.valid <= acc_vld && acc_eop;
        end
        if (acc_vld && acc_eop) begin
            enq.dest <= acc_sop ? port_idx_t'(acc_word[1:0]) : hdr_dest;
            enq.prio <= acc_sop ? prio_t'(acc_word[2]) : hdr_prio;
            enq.head <= acc_sop ? alloc_addr : pkt_head;
            enq.tail <= alloc_addr;
        end
    end

    // ==============================
    // Link memory and read port
    // ==============================
    // Queue append wins; the ingress chain write cannot happen that cycle
    assign lnk_we   = link_req || (acc_vld && !acc_sop);
    assign lnk_addr = link_req ? link_from : last_cell;
    assign lnk_data = link_req ? link_to : alloc_addr;

    always_ff @(posedge clk) begin
        if (lnk_we) link_mem[lnk_addr] <= lnk_data;
    end

    always_ff @(posedge clk) begin
        rd_cell <= cell_mem[rd_addr];
        if (lnk_we && lnk_addr == rd_addr) rd_next <= lnk_data;   // Forward a same-cycle link
        else                               rd_next <= link_mem[rd_addr];
    end

    a_link_no_collide: assert property (@(posedge clk) disable iff (!rst_n)
        !(link_req && acc_vld && !acc_sop));

    a_alloc_has_cell: assert property (@(posedge clk) disable iff (!rst_n)
        acc_vld |-> free_cnt != '0);

endmodule

/* rtl/ingress_arbiter.sv */
module ingress_arbiter (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]      wr_sop,
    input  logic [switch_pkg::NUM_PORTS-1:0]      wr_eop,
    input  logic [switch_pkg::NUM_PORTS-1:0]      wr_vld,
    input  switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] wr_data,
    input  logic                                  room,
    output logic [switch_pkg::NUM_PORTS-1:0]      pause,
    output logic                                  acc_vld,
    output logic                                  acc_sop,
    output logic                                  acc_eop,
    output switch_pkg::word_t                     acc_word
);
    import switch_pkg::*;

    port_idx_t token;     // Port that may write this cycle
    logic      locked;    // Token held until eop
    logic      started;   // Low during the first cycle after reset
    logic      pkt_open;  // Accepted sop that does not end the packet

    // Only the token port may write, and only with room unless mid-packet
    always_comb begin
        pause = '1;
        if (started && (locked || room)) begin
            pause[token] = 1'b0;
        end
    end

    assign acc_vld  = wr_vld[token] && !pause[token];
    assign acc_sop  = wr_sop[token];
    assign acc_eop  = wr_eop[token];
    assign acc_word = wr_data[token];
    assign pkt_open = acc_vld && acc_sop && !acc_eop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
            locked  <= 1'b0;
            token   <= '0;
        end else begin
            started <= 1'b1;
            if (pkt_open) begin
                locked <= 1'b1;
            end else if (acc_vld && acc_eop) begin
                locked <= 1'b0;                   // Token moves on next idle cycle
            end
            if (started && !locked && !pkt_open) begin
                token <= token + 1'b1;
            end
        end
    end

    // Sources must respect pause
    a_no_write_in_pause: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_vld & pause) == '0);

endmodule

/* rtl/switch_pkg.sv */
package switch_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int NUM_PORTS     = 4;
    localparam int NUM_PRIOS     = 2;
    localparam int NUM_CELLS     = 64;
    localparam int MAX_PKT_WORDS = 16;   // Longest packet, header included

    // ==============================
    // Plain vector types
    // ==============================
    typedef logic [15:0]                    word_t;
    typedef logic [$clog2(NUM_PORTS)-1:0]   port_idx_t;
    typedef logic [$clog2(NUM_PRIOS)-1:0]   prio_t;        // 1 is the high priority
    typedef logic [$clog2(NUM_CELLS)-1:0]   cell_addr_t;
    typedef logic [$clog2(NUM_CELLS):0]     cell_count_t;  // Must hold NUM_CELLS itself

    // One buffer cell as stored in the data memory
    typedef struct packed {
        word_t data;
        logic  eop;
    } cell_t;

    // Packet handed from the buffer to the output queues
    typedef struct packed {
        logic       valid;
        port_idx_t  dest;
        prio_t      prio;
        cell_addr_t head;   // First cell of the packet
        cell_addr_t tail;   // Cell holding the eop word
    } enq_req_t;

    // Egress reader FSM
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        STREAM
    } rd_state_t;

endpackage
